/* src/controlUnit_consts.svh */
`ifndef CONTROLUNIT_CONSTS_SVH
`define CONTROLUNIT_CONSTS_SVH

`default_nettype none

// instruction fields
`define OPCODE_RTYPE     6'h00

// supported R-type funct codes
`define FUNCT_MULT       6'h18
`define FUNCT_DIV        6'h1A
`define FUNCT_MFHI       6'h10
`define FUNCT_MFLO       6'h12
`define FUNCT_JR         6'h08

// register write-back source
`define MEMTOREG_HI      3'd2
`define MEMTOREG_LO      3'd3

// next PC source
`define PCSRC_ALU        2'd0
`define PCSRC_EXCVEC     2'd3

// ALU operand selects
`define ALUSRCA_PC       2'd0
`define ALUSRCA_REGA     2'd1
`define ALUSRCB_FOUR     3'd1

// ALU operations
`define ALUOP_ADD        3'd0
`define ALUOP_PASSA      3'd1

// exception cause codes, written with EPC
`define CAUSE_NONE       2'd0
`define CAUSE_OPCODE     2'd1
`define CAUSE_OVERFLOW   2'd2
`define CAUSE_DIVZERO    2'd3

// execute cycles spent in mult and div
`define MULDIV_CYCLES    4

`default_nettype wire

`endif

/* src/controlPkg.sv */
`default_nettype none

package controlPkg;

    // instruction register fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // datapath selector widths
    typedef logic [2:0] memToReg_t;
    typedef logic [1:0] aluSrcA_t;
    typedef logic [2:0] aluSrcB_t;
    typedef logic [2:0] aluOp_t;
    typedef logic [1:0] pcSource_t;
    typedef logic [1:0] excCause_t;

    typedef enum logic [2:0] {
        classMult      = 3'd0,
        classDiv       = 3'd1,
        classMfhi      = 3'd2,
        classMflo      = 3'd3,
        classJr        = 3'd4,
        classUndefined = 3'd5
    } instrClass_t;

    typedef enum logic [3:0] {
        stateReset       = 4'd0,
        stateFetch       = 4'd1,
        stateIrLoad      = 4'd2,
        stateDecode      = 4'd3,
        stateMult        = 4'd4,
        stateDiv         = 4'd5,
        stateMfhi        = 4'd6,
        stateMflo        = 4'd7,
        stateJr          = 4'd8,
        stateExcOpcode   = 4'd9,
        stateExcOverflow = 4'd10,
        stateExcDivZero  = 4'd11
    } ctrlState_t;

    // all datapath strobes and selects, 29 bits
    typedef struct packed {
        logic       pcWrite;
        logic [1:0] iorD;
        logic       memRead;
        logic       irWrite;
        logic       writeA;
        logic       writeB;
        logic       aluOutWrite;
        aluSrcA_t   aluSrcA;
        aluSrcB_t   aluSrcB;
        aluOp_t     aluOp;
        pcSource_t  pcSource;
        logic       multOrDiv;
        logic       hiWrite;
        logic       loWrite;
        memToReg_t  memToReg;
        logic       regWrite;
        logic       regDst;
        logic       epcWrite;
        excCause_t  exception;
    } ctrlWord_t;

endpackage

`default_nettype wire

/* src/opcodeDecoder.sv */
`include "controlUnit_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module opcodeDecoder (
    input  wire controlPkg::opcode_t    opcode,
    input  wire controlPkg::funct_t     funct,
    output controlPkg::instrClass_t     instrClass
);

    logic isRType;

    assign isRType = (opcode == `OPCODE_RTYPE);

    // only R-type mult, div, mfhi, mflo and jr are implemented
    always_comb begin
        instrClass = controlPkg::classUndefined;
        if (isRType) begin
            case (funct)
                `FUNCT_MULT: begin
                    instrClass = controlPkg::classMult;
                end
                `FUNCT_DIV: begin
                    instrClass = controlPkg::classDiv;
                end
                `FUNCT_MFHI: begin
                    instrClass = controlPkg::classMfhi;
                end
                `FUNCT_MFLO: begin
                    instrClass = controlPkg::classMflo;
                end
                `FUNCT_JR: begin
                    instrClass = controlPkg::classJr;
                end
                default: begin
                    // unknown funct traps like a bad opcode
                    instrClass = controlPkg::classUndefined;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/controlSequencer.sv */
`include "controlUnit_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire controlPkg::instrClass_t instrClass,
    input  wire logic                    divZero,
    input  wire logic                    overflow,
    output controlPkg::ctrlState_t       state,
    output logic [1:0]                   muldivPhase
);

    controlPkg::ctrlState_t stateNext;
    logic [1:0]             phaseCount;
    logic                   inMulDiv;
    logic                   lastPhase;

    assign inMulDiv    = (state == controlPkg::stateMult) || (state == controlPkg::stateDiv);
    assign lastPhase   = (phaseCount == 2'(`MULDIV_CYCLES - 1));
    assign muldivPhase = phaseCount;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= controlPkg::stateReset;
            phaseCount <= '0;
        end else begin
            state <= stateNext;
            // decode precedes every mult/div, so the count starts at 0
            if (inMulDiv) begin
                phaseCount <= phaseCount + 2'd1;
            end else begin
                phaseCount <= '0;
            end
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            controlPkg::stateReset: begin
                stateNext = controlPkg::stateFetch;
            end
            controlPkg::stateFetch: begin
                stateNext = controlPkg::stateIrLoad;
            end
            controlPkg::stateIrLoad: begin
                stateNext = controlPkg::stateDecode;
            end
            controlPkg::stateDecode: begin
                // IR is valid from here on, class is stable
                case (instrClass)
                    controlPkg::classMult: stateNext = controlPkg::stateMult;
                    controlPkg::classDiv:  stateNext = controlPkg::stateDiv;
                    controlPkg::classMfhi: stateNext = controlPkg::stateMfhi;
                    controlPkg::classMflo: stateNext = controlPkg::stateMflo;
                    controlPkg::classJr:   stateNext = controlPkg::stateJr;
                    default:               stateNext = controlPkg::stateExcOpcode;
                endcase
            end
            controlPkg::stateMult: begin
                // overflow only counts on the final cycle
                if (lastPhase) begin
                    stateNext = overflow ? controlPkg::stateExcOverflow
                                         : controlPkg::stateFetch;
                end
            end
            controlPkg::stateDiv: begin
                if (lastPhase) begin
                    stateNext = divZero ? controlPkg::stateExcDivZero
                                        : controlPkg::stateFetch;
                end
            end
            controlPkg::stateMfhi,
            controlPkg::stateMflo,
            controlPkg::stateJr: begin
                stateNext = controlPkg::stateFetch;
            end
            controlPkg::stateExcOpcode,
            controlPkg::stateExcOverflow,
            controlPkg::stateExcDivZero: begin
                // vector already loaded into PC
                stateNext = controlPkg::stateFetch;
            end
            default: begin
                stateNext = controlPkg::stateFetch;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/controlWordEncoder.sv */
`include "controlUnit_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module controlWordEncoder (
    input  wire controlPkg::ctrlState_t state,
    input  wire logic [1:0]             muldivPhase,
    output controlPkg::ctrlWord_t       ctrl
);

    controlPkg::excCause_t cause;
    logic                  lastPhase;
    logic                  hiLoWindow;

    assign lastPhase = (muldivPhase == 2'(`MULDIV_CYCLES - 1));

    // HI/LO written between the first and the last execute cycle
    assign hiLoWindow = (muldivPhase != 2'd0) && !lastPhase;

    always_comb begin
        case (state)
            controlPkg::stateExcOpcode:   cause = `CAUSE_OPCODE;
            controlPkg::stateExcOverflow: cause = `CAUSE_OVERFLOW;
            controlPkg::stateExcDivZero:  cause = `CAUSE_DIVZERO;
            default:                      cause = `CAUSE_NONE;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (state)
            controlPkg::stateFetch: begin
                // read instruction, PC + 4
                ctrl.memRead  = 1'b1;
                ctrl.pcWrite  = 1'b1;
                ctrl.aluSrcA  = `ALUSRCA_PC;
                ctrl.aluSrcB  = `ALUSRCB_FOUR;
                ctrl.aluOp    = `ALUOP_ADD;
                ctrl.pcSource = `PCSRC_ALU;
            end
            controlPkg::stateIrLoad: begin
                ctrl.irWrite = 1'b1;
            end
            controlPkg::stateDecode: begin
                ctrl.writeA = 1'b1;
                ctrl.writeB = 1'b1;
            end
            controlPkg::stateMult,
            controlPkg::stateDiv: begin
                // last cycle idles while the flag is sampled
                ctrl.multOrDiv = !lastPhase;
                ctrl.hiWrite   = hiLoWindow;
                ctrl.loWrite   = hiLoWindow;
            end
            controlPkg::stateMfhi: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = `MEMTOREG_HI;
            end
            controlPkg::stateMflo: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = `MEMTOREG_LO;
            end
            controlPkg::stateJr: begin
                // rs passes through the ALU into PC
                ctrl.aluSrcA  = `ALUSRCA_REGA;
                ctrl.aluOp    = `ALUOP_PASSA;
                ctrl.pcSource = `PCSRC_ALU;
                ctrl.pcWrite  = 1'b1;
            end
            controlPkg::stateExcOpcode,
            controlPkg::stateExcOverflow,
            controlPkg::stateExcDivZero: begin
                ctrl.epcWrite  = 1'b1;
                ctrl.pcWrite   = 1'b1;
                ctrl.pcSource  = `PCSRC_EXCVEC;
                ctrl.exception = cause;
            end
            default: begin
                // stateReset keeps everything low
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire controlPkg::opcode_t opcode,
    input  wire controlPkg::funct_t  funct,
    input  wire logic                divZero,
    input  wire logic                overflow,
    output controlPkg::ctrlWord_t    ctrl
);

    controlPkg::instrClass_t instrClass;
    controlPkg::ctrlState_t  state;
    logic [1:0]              muldivPhase;

    opcodeDecoder u_decoder (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    controlSequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .instrClass  (instrClass),
        .divZero     (divZero),
        .overflow    (overflow),
        .state       (state),
        .muldivPhase (muldivPhase)
    );

    // Moore outputs, decoded from state only
    controlWordEncoder u_encoder (
        .state       (state),
        .muldivPhase (muldivPhase),
        .ctrl        (ctrl)
    );

endmodule

`default_nettype wire

/* bench/controlUnit_assert.sv */
`include "controlUnit_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module controlUnitAssert (
    input wire logic                  clk,
    input wire logic                  reset,
    input wire controlPkg::ctrlWord_t ctrl
);

    // everything low while reset is held
    resetClear: assert property (@(posedge clk) reset |-> ctrl == '0)
        else $error("control word not cleared during reset");

    // no instruction here uses these datapath fields
    unusedLow: assert property (@(posedge clk)
        ctrl.iorD == 2'd0 && !ctrl.aluOutWrite && !ctrl.regDst)
        else $error("unused control field driven high");

    // at most one phase strobe per cycle
    onePhase: assert property (@(posedge clk) disable iff (reset)
        $onehot0({ctrl.memRead, ctrl.irWrite, ctrl.writeA, ctrl.regWrite,
                  ctrl.multOrDiv, ctrl.epcWrite}))
        else $error("more than one phase strobe active in one cycle");

    regPair: assert property (@(posedge clk) ctrl.writeA == ctrl.writeB)
        else $error("register A and B loads out of step");

    hiLoPair: assert property (@(posedge clk)
        ctrl.hiWrite == ctrl.loWrite && (!ctrl.hiWrite || ctrl.multOrDiv))
        else $error("HI/LO write outside a mult/div cycle or out of step");

    excFields: assert property (@(posedge clk) disable iff (reset)
        ctrl.epcWrite |-> ctrl.pcWrite && ctrl.pcSource == `PCSRC_EXCVEC
                          && ctrl.exception != `CAUSE_NONE)
        else $error("exception cycle without vector load or cause");

    causeOnlyWithEpc: assert property (@(posedge clk)
        (ctrl.exception != `CAUSE_NONE) |-> ctrl.epcWrite)
        else $error("exception cause set without EPC write");

    excThenFetch: assert property (@(posedge clk) disable iff (reset)
        ctrl.epcWrite |=> ctrl.memRead)
        else $error("fetch did not follow an exception cycle");

endmodule

`default_nettype wire

/* bench/controlUnitTb.sv */
`include "controlUnit_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 2;
    localparam int NUM_INSTR     = 80;
    localparam int DRAIN_CYCLES  = 9;
    localparam int SEED          = 36295;
    // 9 cycles per instruction, two more for reset and drain
    localparam int WATCHDOG_TIME = (NUM_INSTR + 2) * 9 * CLK_PERIOD;

    logic                  clk;
    logic                  reset;
    controlPkg::opcode_t   opcode;
    controlPkg::funct_t    funct;
    logic                  divZero;
    logic                  overflow;
    controlPkg::ctrlWord_t ctrl;

    int   errorCount = 0;
    int   instrCount = 0;
    logic sawHiWrite = 1'b0;
    logic trapExpected = 1'b0;

    logic                   isRType;
    logic                   isMult;
    logic                   isDiv;
    logic                   isMulDiv;
    logic                   decodeMulDiv;
    logic                   jrCycle;
    controlPkg::ctrlState_t expectedExec;
    controlPkg::ctrlState_t muldivExit;

    controlUnit u_dut (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .funct    (funct),
        .divZero  (divZero),
        .overflow (overflow),
        .ctrl     (ctrl)
    );

    bind controlUnit controlUnitAssert u_assert (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl)
    );

    // reference classification of the held instruction
    assign isRType      = (opcode == `OPCODE_RTYPE);
    assign isMult       = isRType && (funct == `FUNCT_MULT);
    assign isDiv        = isRType && (funct == `FUNCT_DIV);
    assign isMulDiv     = isMult || isDiv;
    assign decodeMulDiv = ctrl.writeA && isMulDiv;
    assign jrCycle      = ctrl.pcWrite && (ctrl.aluOp == `ALUOP_PASSA);

    assign expectedExec = isMult ? controlPkg::stateMult :
                          isDiv ? controlPkg::stateDiv :
                          (isRType && funct == `FUNCT_MFHI) ? controlPkg::stateMfhi :
                          (isRType && funct == `FUNCT_MFLO) ? controlPkg::stateMflo :
                          (isRType && funct == `FUNCT_JR) ? controlPkg::stateJr :
                          controlPkg::stateExcOpcode;

    assign muldivExit = !trapExpected ? controlPkg::stateFetch :
                        isMult ? controlPkg::stateExcOverflow : controlPkg::stateExcDivZero;

    function automatic controlPkg::ctrlWord_t expectWord(input controlPkg::ctrlState_t step,
                                                          input logic hiLo);
        controlPkg::ctrlWord_t w;
        w = '0;
        case (step)
            controlPkg::stateFetch: begin
                w.memRead  = 1'b1;
                w.pcWrite  = 1'b1;
                w.aluSrcA  = `ALUSRCA_PC;
                w.aluSrcB  = `ALUSRCB_FOUR;
                w.aluOp    = `ALUOP_ADD;
                w.pcSource = `PCSRC_ALU;
            end
            controlPkg::stateIrLoad: w.irWrite = 1'b1;
            controlPkg::stateDecode: begin
                w.writeA = 1'b1;
                w.writeB = 1'b1;
            end
            controlPkg::stateMult, controlPkg::stateDiv: begin
                w.multOrDiv = 1'b1;
                w.hiWrite   = hiLo;
                w.loWrite   = hiLo;
            end
            controlPkg::stateMfhi, controlPkg::stateMflo: begin
                w.regWrite = 1'b1;
                w.memToReg = (step == controlPkg::stateMfhi) ? `MEMTOREG_HI : `MEMTOREG_LO;
            end
            controlPkg::stateJr: begin
                w.pcWrite  = 1'b1;
                w.aluSrcA  = `ALUSRCA_REGA;
                w.aluOp    = `ALUOP_PASSA;
                w.pcSource = `PCSRC_ALU;
            end
            controlPkg::stateExcOpcode,
            controlPkg::stateExcOverflow,
            controlPkg::stateExcDivZero: begin
                w.epcWrite  = 1'b1;
                w.pcWrite   = 1'b1;
                w.pcSource  = `PCSRC_EXCVEC;
                w.exception = (step == controlPkg::stateExcOpcode) ? `CAUSE_OPCODE :
                              (step == controlPkg::stateExcOverflow) ? `CAUSE_OVERFLOW :
                              `CAUSE_DIVZERO;
            end
            default: w = '0;
        endcase
        return w;
    endfunction

    task automatic reportMismatch(input string name, input string field,
                                  input logic [28:0] expected, input logic [28:0] actual);
        errorCount++;
        $display("Mismatch %s: %s expected %h actual %h", name, field, expected, actual);
    endtask

    resetIdle: assert property (@(posedge clk) (reset || $fell(reset)) |-> ctrl == '0)
        else reportMismatch("reset", "ctrl", '0, $sampled(ctrl));
    firstFetch: assert property (@(posedge clk)
        $fell(reset) |=> ctrl == expectWord(controlPkg::stateFetch, 1'b0))
        else reportMismatch("reset_release", "ctrl", expectWord(controlPkg::stateFetch, 1'b0),
                            $sampled(ctrl));
    irAfterFetch: assert property (@(posedge clk) disable iff (reset)
        ctrl.memRead |=> ctrl == expectWord(controlPkg::stateIrLoad, 1'b0))
        else reportMismatch("irload", "ctrl", expectWord(controlPkg::stateIrLoad, 1'b0),
                            $sampled(ctrl));
    decodeAfterIr: assert property (@(posedge clk) disable iff (reset)
        ctrl.irWrite |=> ctrl == expectWord(controlPkg::stateDecode, 1'b0))
        else reportMismatch("decode", "ctrl", expectWord(controlPkg::stateDecode, 1'b0),
                            $sampled(ctrl));
    // mfhi, mflo, jr, the opcode trap and the first mult/div cycle
    firstExec: assert property (@(posedge clk) disable iff (reset)
        ctrl.writeA |=> ctrl == expectWord(expectedExec, 1'b0))
        else reportMismatch("first_exec", "ctrl", expectWord(expectedExec, 1'b0),
                            $sampled(ctrl));
    mulDivHiLo: assert property (@(posedge clk) disable iff (reset)
        ($past(decodeMulDiv, 2) || $past(decodeMulDiv, 3))
            |-> ctrl == expectWord(controlPkg::stateMult, 1'b1))
        else reportMismatch("muldiv_hilo", "ctrl", expectWord(controlPkg::stateMult, 1'b1),
                            $sampled(ctrl));
    mulDivIdle: assert property (@(posedge clk) disable iff (reset)
        $past(decodeMulDiv, 4) |-> ctrl == '0)
        else reportMismatch("muldiv_idle", "ctrl", '0, $sampled(ctrl));
    mulDivExit: assert property (@(posedge clk) disable iff (reset)
        $past(decodeMulDiv, 5) |-> ctrl == expectWord(muldivExit, 1'b0))
        else reportMismatch("muldiv_exit", "ctrl", expectWord(muldivExit, 1'b0),
                            $sampled(ctrl));
    mulDivGap: assert property (@(posedge clk) disable iff (reset)
        ($past(decodeMulDiv, 5) && !trapExpected) |-> $past(ctrl.memRead, 7))
        else reportMismatch("muldiv_gap", "memRead 7 cycles back", 29'd1, 29'd0);
    singleGap: assert property (@(posedge clk) disable iff (reset)
        (ctrl.regWrite || jrCycle) |-> $past(ctrl.memRead, 3))
        else reportMismatch("single_gap", "memRead 3 cycles back", 29'd1, 29'd0);
    backToFetch: assert property (@(posedge clk) disable iff (reset)
        (ctrl.regWrite || ctrl.epcWrite || jrCycle)
            |=> ctrl == expectWord(controlPkg::stateFetch, 1'b0))
        else reportMismatch("back_to_fetch", "ctrl", expectWord(controlPkg::stateFetch, 1'b0),
                            $sampled(ctrl));

    task automatic applyInstruction(input int index);
        int                 kind;
        controlPkg::funct_t pick;
        kind   = (index < 6) ? index : int'($urandom % 6);
        pick   = 6'($urandom);
        opcode = `OPCODE_RTYPE;
        case (kind)
            0: funct = `FUNCT_MULT;
            1: funct = `FUNCT_DIV;
            2: funct = `FUNCT_MFHI;
            3: funct = `FUNCT_MFLO;
            4: funct = `FUNCT_JR;
            default: begin
                // undefined either by opcode or by funct
                if ($urandom % 2 == 0) begin
                    // a valid funct behind a non R-type opcode
                    opcode = 6'(1 + $urandom % 63);
                    pick   = `FUNCT_MULT;
                end else if (pick inside {`FUNCT_MULT, `FUNCT_DIV, `FUNCT_MFHI,
                                          `FUNCT_MFLO, `FUNCT_JR}) begin
                    pick = 6'h3F;
                end
                funct = pick;
            end
        endcase
    endtask

    task automatic stepStimulus(input logic allowNew);
        logic lastMulDiv;
        @(negedge clk);
        // idle cycle right after the HI/LO window is the last mult/div cycle
        lastMulDiv = sawHiWrite && (ctrl == '0);
        sawHiWrite = ctrl.hiWrite;
        divZero    = lastMulDiv ? 1'($urandom % 2) : 1'b0;
        overflow   = lastMulDiv ? 1'($urandom % 2) : 1'b0;
        if (lastMulDiv) begin
            trapExpected = (isMult && overflow) || (isDiv && divZero);
        end
        if (allowNew && ctrl.irWrite) begin
            applyInstruction(instrCount);
            instrCount++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: run still busy after %0d ns", WATCHDOG_TIME);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        reset    = 1'b1;
        opcode   = '0;
        funct    = '0;
        divZero  = 1'b0;
        overflow = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (instrCount < NUM_INSTR) begin
            stepStimulus(1'b1);
        end
        repeat (DRAIN_CYCLES) begin
            stepStimulus(1'b0);
        end
        $display("run complete: %0d instructions, %0d errors", instrCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+src
src/controlPkg.sv
src/opcodeDecoder.sv
src/controlSequencer.sv
src/controlWordEncoder.sv
src/controlUnit.sv
bench/controlUnit_assert.sv
bench/controlUnitTb.sv

/* run.sh */
#!/bin/sh
# build and run the controlUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
    --top-module controlUnitTb --Mdir obj_dir -o simControlUnit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/simControlUnit)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "simulation did not report a clean run"
exit 1
